// ==== hdl/tenyr_cfg.svh ====
`ifndef TENYR_CFG_SVH
`define TENYR_CFG_SVH

// Address of the first instruction after reset
`define TENYR_RESET_VECTOR 32'h0000_0100

// Depth of the shared word memory
`define TENYR_MEM_WORDS 1024

// All-ones word stops the core
`define TENYR_ILLEGAL 32'hffff_ffff

`endif

// ==== hdl/isaPkg.sv ====
package isaPkg;

    typedef logic [3:0] opT;           // Operation code field
    typedef logic signed [11:0] immT;  // Raw immediate field

    localparam opT opOr    = 4'h0;
    localparam opT opAnd   = 4'h1;
    localparam opT opAdd   = 4'h2;
    localparam opT opMul   = 4'h3;
    localparam opT opRsv4  = 4'h4;     // Reserved code yields zero
    localparam opT opShl   = 4'h5;
    localparam opT opLt    = 4'h6;
    localparam opT opEq    = 4'h7;
    localparam opT opGt    = 4'h8;
    localparam opT opAndn  = 4'h9;
    localparam opT opXor   = 4'ha;
    localparam opT opSub   = 4'hb;
    localparam opT opXnor  = 4'hc;
    localparam opT opShr   = 4'hd;
    localparam opT opNe    = 4'he;
    localparam opT opRsv15 = 4'hf;     // Reserved code yields zero

endpackage

// ==== hdl/busPkg.sv ====
package busPkg;

    typedef logic [31:0] wordT;    // Data word
    typedef logic [31:0] addrT;    // Word address decoded on its low bits by memory

    // Index 0 reads zero and index 15 reads the next program counter
    typedef logic [3:0] regIdxT;

    typedef enum logic [1:0] {
        stopped,
        running,
        halted
    } runStateT;

endpackage

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           writeEn,
    input  busPkg::regIdxT idxZ,
    input  busPkg::regIdxT idxX,
    input  busPkg::regIdxT idxY,
    input  busPkg::wordT   writeData,
    input  busPkg::wordT   nextPc,
    output busPkg::wordT   valZ,
    output busPkg::wordT   valX,
    output busPkg::wordT   valY
);
    import busPkg::*;

    wordT regs [1:14];  // Only the general registers are stored

    function automatic wordT readReg(input regIdxT idx);
        wordT val;
        if (idx == 4'd0) begin
            val = '0;
        end else if (idx == 4'd15) begin
            val = nextPc;       // Program counter alias
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        valZ = readReg(idxZ);
        valX = readReg(idxX);
        valY = readReg(idxY);
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 1; i <= 14; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && idxZ != 4'd0 && idxZ != 4'd15) begin
            regs[idxZ] <= writeData;  // Branches go through the core instead
        end
    end

endmodule

// ==== hdl/insnDecode.sv ====
`timescale 1ns/1ps
`include "tenyr_cfg.svh"

module insnDecode (
    input  busPkg::wordT   insn,
    output busPkg::regIdxT idxZ,
    output busPkg::regIdxT idxX,
    output busPkg::regIdxT idxY,
    output isaPkg::opT     op,
    output busPkg::wordT   imm,
    output logic           form,
    output logic           store,
    output logic           deref,
    output logic           branch,
    output logic           illegal
);
    import isaPkg::*;

    immT immField;

    assign form     = insn[30];
    assign store    = insn[29];
    assign deref    = insn[28];
    assign idxZ     = insn[27:24];
    assign idxX     = insn[23:20];
    assign idxY     = insn[19:16];
    assign op       = insn[15:12];
    assign immField = insn[11:0];

    assign imm = {{20{immField[11]}}, immField};  // Sign extend to a word

    // Writing the program counter alias is a jump
    assign branch  = (idxZ == 4'd15) && !store;
    assign illegal = (insn == `TENYR_ILLEGAL);

endmodule

// ==== hdl/aluExec.sv ====
`timescale 1ns/1ps

module aluExec (
    input  logic         clk,
    input  logic         reset_n,
    input  logic         en,
    input  isaPkg::opT   op,
    input  busPkg::wordT opX,
    input  busPkg::wordT opY,
    input  busPkg::wordT addend,
    output busPkg::wordT rhs
);
    import isaPkg::*;
    import busPkg::*;

    wordT result;  // Operation result before the addend

    always_comb begin
        case (op)
            opOr:    result = opX | opY;
            opAnd:   result = opX & opY;
            opAdd:   result = opX + opY;
            opMul:   result = opX * opY;
            opShl:   result = opX << opY;                           // Logical
            opLt:    result = {32{$signed(opX) < $signed(opY)}};    // All ones if true
            opEq:    result = {32{opX == opY}};
            opGt:    result = {32{$signed(opX) > $signed(opY)}};
            opAndn:  result = opX & ~opY;
            opXor:   result = opX ^ opY;
            opSub:   result = opX - opY;
            opXnor:  result = opX ^~ opY;
            opShr:   result = opX >> opY;                           // Logical
            opNe:    result = {32{opX != opY}};
            opRsv4,
            opRsv15: result = '0;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rhs <= '0;
        end else if (en) begin
            rhs <= result + addend;
        end
    end

endmodule

// ==== hdl/coreSeq.sv ====
`timescale 1ns/1ps
`include "tenyr_cfg.svh"

module coreSeq (
    input  logic         clk,
    input  logic         reset_n,
    input  logic         runEn,
    output busPkg::addrT fetchAddr,
    input  busPkg::wordT fetchData,
    output logic         dataStrobe,
    output logic         dataWrite,
    output busPkg::wordT dataAddr,
    output busPkg::wordT dataWdata,
    input  busPkg::wordT dataRdata,
    output logic         retire,
    output logic         illegalSeen
);
    import busPkg::*;
    import isaPkg::*;

    logic [3:0] phase;  // One-hot fetch, execute, memory, writeback
    wordT   insn;
    wordT   rhs;        // ALU result plus addend
    wordT   memWord;    // Load data kept for writeback
    wordT   nextPc;
    regIdxT idxZ;
    regIdxT idxX;
    regIdxT idxY;
    opT     op;
    wordT   imm;
    logic   form;
    logic   store;
    logic   deref;
    logic   branch;
    logic   illegal;
    wordT   valZ;
    wordT   valX;
    wordT   valY;
    wordT   rightOp;
    wordT   addend;
    wordT   target;
    wordT   writeData;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            phase     <= 4'b0000;
            fetchAddr <= `TENYR_RESET_VECTOR;
        end else begin
            if (phase == 4'b0000 || phase[3]) begin
                phase <= runEn ? 4'b0001 : 4'b0000;  // Run enable checked only here
            end else if (phase[1] && illegal) begin
                phase <= 4'b0000;                     // Abandon the illegal word
            end else begin
                phase <= phase << 1;
            end
            if (phase[2]) begin
                fetchAddr <= branch ? target : nextPc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (phase[0]) begin
            insn <= fetchData;
        end
        if (phase[2]) begin
            memWord <= dataRdata;
        end
    end

    assign nextPc = fetchAddr + 32'd1;

    insnDecode decode (
        .insn    (insn),
        .idxZ    (idxZ),
        .idxX    (idxX),
        .idxY    (idxY),
        .op      (op),
        .imm     (imm),
        .form    (form),
        .store   (store),
        .deref   (deref),
        .branch  (branch),
        .illegal (illegal)
    );

    // Form 1 swaps the immediate and Y
    assign rightOp = form ? imm : valY;
    assign addend  = form ? valY : imm;

    aluExec exec (
        .clk     (clk),
        .reset_n (reset_n),
        .en      (phase[1]),
        .op      (op),
        .opX     (valX),
        .opY     (rightOp),
        .addend  (addend),
        .rhs     (rhs)
    );

    assign dataStrobe = phase[2] && (deref || store);
    assign dataWrite  = phase[2] && store;
    assign dataAddr   = deref ? rhs : valZ;
    assign dataWdata  = deref ? valZ : rhs;
    assign target     = deref ? dataRdata : rhs;   // Branch through memory when dereferenced

    assign writeData   = deref ? memWord : rhs;
    assign retire      = phase[3];
    assign illegalSeen = phase[1] && illegal;

    regFile regs (
        .clk       (clk),
        .reset_n   (reset_n),
        .writeEn   (phase[3] && !store),
        .idxZ      (idxZ),
        .idxX      (idxX),
        .idxY      (idxY),
        .writeData (writeData),
        .nextPc    (nextPc),
        .valZ      (valZ),
        .valX      (valX),
        .valY      (valY)
    );

endmodule

// ==== hdl/runControl.sv ====
`timescale 1ns/1ps

module runControl (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             runStrobe,
    input  logic             stopStrobe,
    input  logic             illegalSeen,
    input  logic             retire,
    output logic             runEn,
    output busPkg::runStateT runState,
    output busPkg::wordT     retireCount
);
    import busPkg::*;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            runState    <= stopped;
            retireCount <= '0;
        end else begin
            if (illegalSeen) begin
                runState <= halted;  // Also when stopped with the word in flight
            end else begin
                case (runState)
                    stopped: begin
                        if (runStrobe) begin
                            runState <= running;
                        end
                    end
                    running: begin
                        if (stopStrobe) begin
                            runState <= stopped;
                        end
                    end
                    halted:  runState <= halted;  // Left only through reset
                    default: runState <= stopped;
                endcase
            end
            if (retire) begin
                retireCount <= retireCount + 32'd1;
            end
        end
    end

    assign runEn = (runState == running);

endmodule

// ==== hdl/wordRam.sv ====
`timescale 1ns/1ps
`include "tenyr_cfg.svh"

module wordRam (
    input  logic         clk,
    input  busPkg::addrT fetchAddr,
    output busPkg::wordT fetchData,
    input  logic         dataStrobe,
    input  logic         dataWrite,
    input  busPkg::wordT dataAddr,
    input  busPkg::wordT dataWdata,
    output busPkg::wordT dataRdata,
    input  logic         loadStrobe,
    input  busPkg::addrT loadAddr,
    input  busPkg::wordT loadData,
    input  busPkg::addrT peekAddr,
    output busPkg::wordT peekData
);
    import busPkg::*;

    localparam int addrBits = $clog2(`TENYR_MEM_WORDS);

    wordT mem [`TENYR_MEM_WORDS];

    // Three asynchronous read ports on the low address bits
    assign fetchData = mem[fetchAddr[addrBits-1:0]];
    assign dataRdata = mem[dataAddr[addrBits-1:0]];
    assign peekData  = mem[peekAddr[addrBits-1:0]];

    always_ff @(posedge clk) begin
        if (dataStrobe && dataWrite) begin
            mem[dataAddr[addrBits-1:0]] <= dataWdata;
        end
        if (loadStrobe) begin
            mem[loadAddr[addrBits-1:0]] <= loadData;  // Later update wins on a clash
        end
    end

endmodule

// ==== hdl/tenyrSystem.sv ====
`timescale 1ns/1ps

module tenyrSystem (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             runStrobe,
    input  logic             stopStrobe,
    input  logic             loadStrobe,
    input  busPkg::addrT     loadAddr,
    input  busPkg::wordT     loadData,
    input  busPkg::addrT     peekAddr,
    output busPkg::wordT     peekData,
    output busPkg::runStateT runState,
    output busPkg::wordT     retireCount
);
    import busPkg::*;

    logic runEn;
    logic retire;
    logic illegalSeen;
    logic dataStrobe;
    logic dataWrite;
    addrT fetchAddr;
    wordT fetchData;
    wordT dataAddr;
    wordT dataWdata;
    wordT dataRdata;

    coreSeq core (
        .clk         (clk),
        .reset_n     (reset_n),
        .runEn       (runEn),
        .fetchAddr   (fetchAddr),
        .fetchData   (fetchData),
        .dataStrobe  (dataStrobe),
        .dataWrite   (dataWrite),
        .dataAddr    (dataAddr),
        .dataWdata   (dataWdata),
        .dataRdata   (dataRdata),
        .retire      (retire),
        .illegalSeen (illegalSeen)
    );

    runControl ctrl (
        .clk         (clk),
        .reset_n     (reset_n),
        .runStrobe   (runStrobe),
        .stopStrobe  (stopStrobe),
        .illegalSeen (illegalSeen),
        .retire      (retire),
        .runEn       (runEn),
        .runState    (runState),
        .retireCount (retireCount)
    );

    wordRam ram (
        .clk        (clk),
        .fetchAddr  (fetchAddr),
        .fetchData  (fetchData),
        .dataStrobe (dataStrobe),
        .dataWrite  (dataWrite),
        .dataAddr   (dataAddr),
        .dataWdata  (dataWdata),
        .dataRdata  (dataRdata),
        .loadStrobe (loadStrobe),
        .loadAddr   (loadAddr),
        .loadData   (loadData),
        .peekAddr   (peekAddr),
        .peekData   (peekData)
    );

endmodule

// ==== testbench/tenyrSystem_asserts.sv ====
`timescale 1ns/1ps

module tenyrSystem_asserts (
    input logic       clk,
    input logic       reset_n,
    input logic [3:0] phase,
    input logic       dataStrobe,
    input logic       dataWrite,
    input logic       retire,
    input logic       illegalSeen
);
    int failCount = 0;  // Read by the testbench at the end of the run

    phaseOneHot: assert property (@(posedge clk) disable iff (!reset_n) $onehot0(phase))
        else begin
            $error("core phase vector has more than one bit set");
            failCount++;
        end

    strobeSingle: assert property (@(posedge clk) disable iff (!reset_n)
        dataStrobe |=> !dataStrobe)
        else begin
            $error("data strobe held for more than one cycle");
            failCount++;
        end

    writeQualified: assert property (@(posedge clk) disable iff (!reset_n)
        dataWrite |-> dataStrobe)
        else begin
            $error("data write without data strobe");
            failCount++;
        end

    retireNotIllegal: assert property (@(posedge clk) disable iff (!reset_n)
        !(retire && illegalSeen))
        else begin
            $error("illegal instruction retired");
            failCount++;
        end

endmodule

bind coreSeq tenyrSystem_asserts coreChecks (
    .clk         (clk),
    .reset_n     (reset_n),
    .phase       (phase),
    .dataStrobe  (dataStrobe),
    .dataWrite   (dataWrite),
    .retire      (retire),
    .illegalSeen (illegalSeen)
);

// ==== testbench/tenyrSystem_tb.sv ====
`timescale 1ns/1ps
`include "tenyr_cfg.svh"

module tenyrSystem_tb;
    import busPkg::*;
    import isaPkg::*;

    localparam addrT dataBase  = 32'h200;  // Data region checked after each run
    localparam int   dataWords = 256;
    localparam opT   opList [14] = '{opOr, opAnd, opAdd, opMul, opShl, opLt, opEq,
                                     opGt, opAndn, opXor, opSub, opXnor, opShr, opNe};

    logic     clk;
    logic     reset_n;
    logic     runStrobe;
    logic     stopStrobe;
    logic     loadStrobe;
    addrT     loadAddr;
    wordT     loadData;
    addrT     peekAddr;
    wordT     peekData;
    runStateT runState;
    wordT     retireCount;

    wordT lfsr = 32'hcc1;
    wordT mMem [`TENYR_MEM_WORDS];  // Model memory image
    wordT mRegs [16];
    addrT pcLoad;                   // Next program word to load
    int   errors;
    int   tests;
    int   testErrors;

    tenyrSystem uut (
        .clk         (clk),
        .reset_n     (reset_n),
        .runStrobe   (runStrobe),
        .stopStrobe  (stopStrobe),
        .loadStrobe  (loadStrobe),
        .loadAddr    (loadAddr),
        .loadData    (loadData),
        .peekAddr    (peekAddr),
        .peekData    (peekData),
        .runState    (runState),
        .retireCount (retireCount)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic stepLfsr();
        logic outBit;
        outBit = lfsr[0];
        lfsr = lfsr >> 1;
        if (outBit) begin
            lfsr = lfsr ^ 32'h8020_0003;  // Taps 32, 22, 2, 1
        end
        return outBit;
    endfunction

    function automatic wordT randBits(input int n);
        wordT r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], stepLfsr()};
        end
        return r;
    endfunction

    function automatic int memIdx(input wordT a);
        return a % `TENYR_MEM_WORDS;
    endfunction

    function automatic wordT fillWord(input addrT a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic wordT enc(input logic f, input logic st, input logic dr,
                                 input regIdxT z, input regIdxT x, input regIdxT y,
                                 input opT op, input int imm);
        logic [11:0] immBits;
        immBits = imm[11:0];
        return {1'b0, f, st, dr, z, x, y, op, immBits};
    endfunction

    function automatic wordT ldImm(input regIdxT z, input int v);
        return enc(1'b0, 1'b0, 1'b0, z, 4'd0, 4'd0, opOr, v);
    endfunction

    function automatic wordT loadReg(input regIdxT z, input int a);
        return enc(1'b0, 1'b0, 1'b1, z, 4'd0, 4'd0, opOr, a);  // Z = mem[a]
    endfunction

    function automatic wordT storeReg(input regIdxT z, input int a);
        return enc(1'b0, 1'b1, 1'b1, z, 4'd0, 4'd0, opOr, a);  // mem[a] = Z
    endfunction

    // ISA reference for the operation before the addend
    function automatic wordT aluRef(input opT op, input wordT a, input wordT b);
        case (op)
            4'h0:    return a | b;
            4'h1:    return a & b;
            4'h2:    return a + b;
            4'h3:    return a * b;
            4'h5:    return a << b;
            4'h6:    return ($signed(a) < $signed(b)) ? 32'hffff_ffff : 32'h0;
            4'h7:    return (a == b) ? 32'hffff_ffff : 32'h0;
            4'h8:    return ($signed(a) > $signed(b)) ? 32'hffff_ffff : 32'h0;
            4'h9:    return a & ~b;
            4'ha:    return a ^ b;
            4'hb:    return a - b;
            4'hc:    return ~(a ^ b);
            4'hd:    return a >> b;
            4'he:    return (a != b) ? 32'hffff_ffff : 32'h0;
            default: return 32'h0;
        endcase
    endfunction

    function automatic wordT readModelReg(input regIdxT idx, input addrT pc);
        if (idx == 4'd0) begin
            return '0;
        end
        if (idx == 4'd15) begin
            return pc + 32'd1;  // Next instruction address
        end
        return mRegs[idx];
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic loadWord(input addrT a, input wordT d);
        loadAddr   = a;
        loadData   = d;
        loadStrobe = 1'b1;
        tick();
        loadStrobe = 1'b0;
        mMem[memIdx(a)] = d;
    endtask

    task automatic emit(input wordT insn);
        loadWord(pcLoad, insn);
        pcLoad = pcLoad + 32'd1;
    endtask

    task automatic peekRead(input addrT a, output wordT d);
        peekAddr = a;
        tick();
        d = peekData;
    endtask

    task automatic peekCheck(input addrT a, input wordT exp, input string what);
        wordT got;
        peekRead(a, got);
        if (got !== exp) begin
            $display("FAIL %0t: %s at %h is %h, expected %h", $time, what, a, got, exp);
            testErrors++;
        end
    endtask

    task automatic beginTest();
        reset_n = 1'b0;
        repeat (8) tick();
        reset_n = 1'b1;
        foreach (mRegs[i]) begin
            mRegs[i] = '0;
        end
        for (int a = dataBase; a < dataBase + dataWords; a++) begin
            loadWord(a, fillWord(a));
        end
        pcLoad = `TENYR_RESET_VECTOR;
    endtask

    task automatic startRun();
        runStrobe = 1'b1;
        tick();
        runStrobe = 1'b0;
    endtask

    task automatic stopRun();
        stopStrobe = 1'b1;
        tick();
        stopStrobe = 1'b0;
    endtask

    task automatic waitState(input runStateT want, input string what);
        int n;
        n = 0;
        while (runState !== want && n < 4000) begin
            tick();
            n++;
        end
        if (runState !== want) begin
            $display("Timeout at %0t: core never reached %s during %s, stuck in %s",
                     $time, want.name(), what, runState.name());
            testErrors++;
        end
    endtask

    // Runs the loaded program on the ISA model until the first illegal word
    task automatic runModel(output int count);
        addrT   pc;
        addrT   next;
        regIdxT zi;
        wordT   insn;
        wordT   vz;
        wordT   vx;
        wordT   vy;
        wordT   imm;
        wordT   rhs;
        wordT   value;
        pc = `TENYR_RESET_VECTOR;
        count = 0;
        while (count < 10000) begin
            insn = mMem[memIdx(pc)];
            if (insn == `TENYR_ILLEGAL) begin
                break;
            end
            zi  = insn[27:24];
            vz  = readModelReg(zi, pc);
            vx  = readModelReg(insn[23:20], pc);
            vy  = readModelReg(insn[19:16], pc);
            imm = {{20{insn[11]}}, insn[11:0]};
            if (insn[30]) begin
                rhs = aluRef(insn[15:12], vx, imm) + vy;  // Form 1 swaps Y and immediate
            end else begin
                rhs = aluRef(insn[15:12], vx, vy) + imm;
            end
            next = pc + 32'd1;
            if (insn[29] && insn[28]) begin
                mMem[memIdx(rhs)] = vz;
            end else if (insn[29]) begin
                mMem[memIdx(vz)] = rhs;
            end else begin
                value = insn[28] ? mMem[memIdx(rhs)] : rhs;
                if (zi == 4'd15) begin
                    next = value;
                end else if (zi != 4'd0) begin
                    mRegs[zi] = value;
                end
            end
            pc = next;
            count++;
        end
    endtask

    task automatic compareModel();
        int   count;
        wordT got;
        runModel(count);
        if (runState !== halted) begin
            $display("FAIL %0t: runState is %s, expected halted", $time, runState.name());
            testErrors++;
        end
        if (retireCount !== count) begin
            $display("FAIL %0t: retireCount %0d, expected %0d", $time, retireCount, count);
            testErrors++;
        end
        for (int a = dataBase; a < dataBase + dataWords; a++) begin
            peekRead(a, got);
            if (got !== mMem[memIdx(a)]) begin
                $display("FAIL %0t: memory %h is %h, expected %h", $time, a, got,
                         mMem[memIdx(a)]);
                testErrors++;
            end
        end
    endtask

    task automatic endTest(input string name);
        tests++;
        if (testErrors == 0) begin
            $display("test %-16s ok", name);
        end else begin
            $display("test %-16s %0d errors", name, testErrors);
        end
        errors += testErrors;
        testErrors = 0;
    endtask

    task automatic buildCountdown(input int n);
        emit(ldImm(4'd1, n));
        emit(ldImm(4'd2, 0));
        emit(enc(1'b0, 1'b0, 1'b0, 4'd2, 4'd2, 4'd0, opAdd, 3));     // Loop body adds 3 to r2
        emit(enc(1'b0, 1'b0, 1'b0, 4'd1, 4'd1, 4'd0, opAdd, -1));
        emit(enc(1'b0, 1'b0, 1'b0, 4'd4, 4'd1, 4'd0, opNe, 0));
        emit(enc(1'b1, 1'b0, 1'b0, 4'd15, 4'd4, 4'd15, opAnd, -4));  // Back 4 while r4 set
        emit(storeReg(4'd2, 'h260));
        emit(storeReg(4'd1, 'h261));
        emit(`TENYR_ILLEGAL);
    endtask

    task automatic testAllOps();
        addrT a;
        wordT opA;
        wordT opB;
        int   imm;
        int   k;
        logic shift;
        beginTest();
        k = 0;
        foreach (opList[i]) begin
            for (int f = 0; f < 2; f++) begin
                a = dataBase + 2 * k;
                shift = (opList[i] == opShl) || (opList[i] == opShr);
                opA = randBits(32);
                opB = shift ? randBits(5) : randBits(32);
                if ((opList[i] == opEq || opList[i] == opNe) && randBits(1) == 1) begin
                    opB = opA;  // Give the equality tests a true case
                end
                imm = shift ? randBits(5) : randBits(12);
                loadWord(a, opA);
                loadWord(a + 1, opB);
                emit(loadReg(4'd1, a));
                emit(loadReg(4'd2, a + 1));
                emit(enc(f[0], 1'b0, 1'b0, 4'd3, 4'd1, 4'd2, opList[i], imm));
                emit(storeReg(4'd3, 'h280 + k));
                k++;
            end
        end
        emit(`TENYR_ILLEGAL);
        startRun();
        waitState(halted, "all operations");
        compareModel();
        endTest("all operations");
    endtask

    task automatic testAliases();
        beginTest();
        emit(ldImm(4'd0, 'h123));                                   // Dropped write
        emit(storeReg(4'd0, 'h240));
        emit(enc(1'b0, 1'b0, 1'b0, 4'd1, 4'd15, 4'd0, opAdd, 0));
        emit(storeReg(4'd1, 'h241));
        emit(storeReg(4'd15, 'h242));
        emit(`TENYR_ILLEGAL);
        startRun();
        waitState(halted, "register aliases");
        compareModel();
        peekCheck('h240, 32'h0, "register 0");
        peekCheck('h241, `TENYR_RESET_VECTOR + 3, "register 15 via add");
        peekCheck('h242, `TENYR_RESET_VECTOR + 5, "register 15 stored");
        endTest("register aliases");
    endtask

    task automatic testMemForms();
        beginTest();
        loadWord('h24d, randBits(32));
        emit(ldImm(4'd1, 'h250));
        emit(enc(1'b0, 1'b0, 1'b1, 4'd2, 4'd1, 4'd0, opOr, -3));   // Load from 24d
        emit(enc(1'b0, 1'b1, 1'b1, 4'd2, 4'd1, 4'd0, opAdd, -8));  // Store to 248
        emit(enc(1'b0, 1'b1, 1'b0, 4'd1, 4'd2, 4'd0, opXor, -1));  // Store at address in r1
        emit(enc(1'b1, 1'b0, 1'b1, 4'd3, 4'd1, 4'd0, opAdd, -16));
        emit(enc(1'b1, 1'b1, 1'b1, 4'd3, 4'd1, 4'd0, opAdd, -4));
        emit(`TENYR_ILLEGAL);
        startRun();
        waitState(halted, "memory forms");
        compareModel();
        endTest("memory forms");
    endtask

    task automatic testCountdown();
        int n;
        beginTest();
        n = 4 + randBits(3);
        buildCountdown(n);
        startRun();
        waitState(halted, "countdown loop");
        compareModel();
        peekCheck('h260, 3 * n, "loop accumulator");
        endTest("countdown loop");
    endtask

    task automatic testIllegal();
        beginTest();
        emit(ldImm(4'd1, 'h77));
        emit(storeReg(4'd1, 'h270));
        emit(`TENYR_ILLEGAL);
        emit(storeReg(4'd1, 'h271));                               // Never reached
        emit(`TENYR_ILLEGAL);
        startRun();
        waitState(halted, "illegal word");
        compareModel();
        peekCheck('h271, fillWord('h271), "store after illegal word");
        startRun();
        repeat (8) tick();
        if (runState !== halted || retireCount !== 2) begin
            $display("FAIL %0t: after runStrobe state %s count %0d, expected halted and 2",
                     $time, runState.name(), retireCount);
            testErrors++;
        end
        endTest("illegal word");
    endtask

    task automatic testStopResume();
        wordT held;
        beginTest();
        buildCountdown(8 + randBits(3));
        startRun();
        repeat (20) tick();
        stopRun();
        waitState(stopped, "stop request");
        repeat (8) tick();
        held = retireCount;                                        // In-flight word is done
        repeat (8) tick();
        if (runState !== stopped || retireCount !== held) begin
            $display("FAIL %0t: core kept running after stop, state %s count %0d",
                     $time, runState.name(), retireCount);
            testErrors++;
        end
        startRun();
        waitState(halted, "resumed run");
        compareModel();
        endTest("stop and resume");
    endtask

    initial begin
        reset_n    = 1'b0;
        runStrobe  = 1'b0;
        stopStrobe = 1'b0;
        loadStrobe = 1'b0;
        loadAddr   = '0;
        loadData   = '0;
        peekAddr   = '0;
        errors     = 0;
        tests      = 0;
        testErrors = 0;
        testAllOps();
        testAliases();
        testMemForms();
        testCountdown();
        testIllegal();
        testStopResume();
        errors += uut.core.coreChecks.failCount;
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== tenyrSystem.f ====
+incdir+hdl
hdl/isaPkg.sv
hdl/busPkg.sv
hdl/regFile.sv
hdl/insnDecode.sv
hdl/aluExec.sv
hdl/coreSeq.sv
hdl/runControl.sv
hdl/wordRam.sv
hdl/tenyrSystem.sv
testbench/tenyrSystem_asserts.sv
testbench/tenyrSystem_tb.sv
